// ==== common/emcPkg.sv ====
package emcPkg;

  // ---------------------------------------------------------------------
  // bus widths
  // ---------------------------------------------------------------------
  localparam int addrW    = 15;  // external address
  localparam int dataW    = 16;  // external data
  localparam int waitW    = 4;   // wait count per region
  localparam int reqAddrW = 14;  // pm, dm and dma request address
  localparam int ioAddrW  = 11;  // io request address
  localparam int rgnN     = 4;   // number of regions / requesters

  // ---------------------------------------------------------------------
  // regions, also used as the grant code
  // ---------------------------------------------------------------------
  typedef enum logic [1:0] {
    rgnPm  = 2'd0,
    rgnDm  = 2'd1,
    rgnIo  = 2'd2,
    rgnDma = 2'd3
  } emcRegion_e;

  // external cycle sequencer
  typedef enum logic [1:0] {
    sIdle   = 2'd0,
    sStrobe = 2'd1,  // selects and strobes low
    sDone   = 2'd2
  } seqState_e;

  // ---------------------------------------------------------------------
  // config registers
  // ---------------------------------------------------------------------
  typedef enum logic {
    cfgWait = 1'b0,  // wait states, one nibble per region
    cfgOvl  = 1'b1   // overlay pages
  } cfgReg_e;

  // wait register: [3:0] pm, [7:4] dm, [11:8] io, [15:12] dma
  localparam logic [dataW-1:0] waitRst = 16'h0000;

  // overlay register: [2:0] pm page, [5:4] dm page
  localparam logic [dataW-1:0] ovlRst = 16'h0000;

  // overlay field positions
  localparam int pmPageLo = 0;
  localparam int pmPageW  = 3;
  localparam int dmPageLo = 4;
  localparam int dmPageW  = 2;

endpackage

// ==== emc/emcArbiter.sv ====
`timescale 1ns/1ps

module emcArbiter
  import emcPkg::*;
(
  input  logic                DSPCLK,
  input  logic                PPclr,
  input  logic                pmValid,
  input  logic                pmWrite,
  input  logic [reqAddrW-1:0] pmAddr,
  input  logic [dataW-1:0]    pmWdata,
  output logic                pmReady,
  output logic                pmDone,
  input  logic                dmValid,
  input  logic                dmWrite,
  input  logic [reqAddrW-1:0] dmAddr,
  input  logic [dataW-1:0]    dmWdata,
  output logic                dmReady,
  output logic                dmDone,
  input  logic                ioValid,
  input  logic                ioWrite,
  input  logic [ioAddrW-1:0]  ioAddr,
  input  logic [dataW-1:0]    ioWdata,
  output logic                ioReady,
  output logic                ioDone,
  input  logic                dmaValid,
  input  logic                dmaWrite,
  input  logic [reqAddrW-1:0] dmaAddr,
  input  logic [dataW-1:0]    dmaWdata,
  output logic                dmaReady,
  output logic                dmaDone,
  input  logic                seqIdle,
  input  logic                seqDone,
  output logic                gntStart,
  output emcRegion_e          gntRegion,
  output logic                gntWrite,
  output logic [reqAddrW-1:0] gntAddr,
  output logic [dataW-1:0]    gntWdata
);

  logic                armed;  // low for the first cycle out of reset
  logic                canGrant;
  emcRegion_e          liveRegion;
  logic                liveWrite;
  logic [reqAddrW-1:0] liveAddr;
  emcRegion_e          heldRegion;
  logic                heldWrite;
  logic [reqAddrW-1:0] heldAddr;

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      armed <= 1'b0;
    end else begin
      armed <= 1'b1;
    end
  end

  // fixed priority pm > dm > io > dma
  assign canGrant = armed & seqIdle;
  assign pmReady  = canGrant & pmValid;
  assign dmReady  = canGrant & dmValid & ~pmValid;
  assign ioReady  = canGrant & ioValid & ~pmValid & ~dmValid;
  assign dmaReady = canGrant & dmaValid & ~pmValid & ~dmValid & ~ioValid;
  assign gntStart = pmReady | dmReady | ioReady | dmaReady;

  always_comb begin
    liveRegion = rgnDma;
    liveWrite  = dmaWrite;
    liveAddr   = dmaAddr;
    gntWdata   = dmaWdata;  // only sampled with gntStart
    if (pmValid) begin
      liveRegion = rgnPm;
      liveWrite  = pmWrite;
      liveAddr   = pmAddr;
      gntWdata   = pmWdata;
    end else if (dmValid) begin
      liveRegion = rgnDm;
      liveWrite  = dmWrite;
      liveAddr   = dmAddr;
      gntWdata   = dmWdata;
    end else if (ioValid) begin
      liveRegion = rgnIo;
      liveWrite  = ioWrite;
      liveAddr   = {{(reqAddrW-ioAddrW){1'b0}}, ioAddr};
      gntWdata   = ioWdata;
    end
  end

  // requester may move on after acceptance, keep the cycle's fields
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      heldRegion <= rgnPm;
      heldWrite  <= 1'b0;
    end else if (gntStart) begin
      heldRegion <= liveRegion;
      heldWrite  <= liveWrite;
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (gntStart) begin
      heldAddr <= liveAddr;
    end
  end

  assign gntRegion = gntStart ? liveRegion : heldRegion;
  assign gntWrite  = gntStart ? liveWrite : heldWrite;
  assign gntAddr   = gntStart ? liveAddr : heldAddr;

  // route completion back to the owner
  assign pmDone  = seqDone & (heldRegion == rgnPm);
  assign dmDone  = seqDone & (heldRegion == rgnDm);
  assign ioDone  = seqDone & (heldRegion == rgnIo);
  assign dmaDone = seqDone & (heldRegion == rgnDma);

endmodule

// ==== emc/emcAddrMap.sv ====
`timescale 1ns/1ps

module emcAddrMap
  import emcPkg::*;
(
  input  logic                DSPCLK,
  input  logic                PPclr,
  input  logic                cfgWe,
  input  logic                cfgAddr,
  input  logic [dataW-1:0]    cfgData,
  input  emcRegion_e          gntRegion,
  input  logic [reqAddrW-1:0] gntAddr,
  input  logic                dmaPage,
  output logic [addrW-1:0]    extAddr,
  output logic [rgnN-1:0]     regionSel
);

  logic [pmPageW-1:0] pmPage;
  logic [dmPageW-1:0] dmPage;

  // ---------------------------------------------------------------------
  // overlay register, only the page fields are kept
  // ---------------------------------------------------------------------
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      pmPage <= ovlRst[pmPageLo +: pmPageW];
      dmPage <= ovlRst[dmPageLo +: dmPageW];
    end else if (cfgWe && (cfgReg_e'(cfgAddr) == cfgOvl)) begin
      pmPage <= cfgData[pmPageLo +: pmPageW];
      dmPage <= cfgData[dmPageLo +: dmPageW];
    end
  end

  // ---------------------------------------------------------------------
  // external address per region
  // ---------------------------------------------------------------------
  always_comb begin
    case (gntRegion)
      rgnPm:   extAddr = {pmPage, gntAddr[11:0]};  // 4K window
      rgnDm:   extAddr = {dmPage, gntAddr[12:0]};  // 8K window
      rgnIo:   extAddr = {{(addrW-ioAddrW){1'b0}}, gntAddr[ioAddrW-1:0]};
      rgnDma:  extAddr = {dmaPage, gntAddr[13:0]};
      default: extAddr = '0;
    endcase
  end

  // one-hot region select, bit n for region code n
  always_comb begin
    regionSel = '0;
    regionSel[gntRegion] = 1'b1;
  end

endmodule

// ==== emc/emcSequencer.sv ====
`timescale 1ns/1ps

module emcSequencer
  import emcPkg::*;
(
  input  logic             DSPCLK,
  input  logic             PPclr,
  input  logic             cfgWe,
  input  logic             cfgAddr,
  input  logic [dataW-1:0] cfgData,
  input  logic             gntStart,
  input  emcRegion_e       gntRegion,
  input  logic             gntWrite,
  input  logic [dataW-1:0] gntWdata,
  input  logic [rgnN-1:0]  regionSel,
  input  logic [dataW-1:0] extDin,
  output logic             pmSelN,
  output logic             dmSelN,
  output logic             ioSelN,
  output logic             dmaSelN,
  output logic             rdN,
  output logic             wrN,
  output logic [dataW-1:0] extDout,
  output logic             extDoe,
  output logic [dataW-1:0] rdData,
  output logic             seqIdle,
  output logic             seqDone
);

  seqState_e        state;
  seqState_e        nextState;
  logic [dataW-1:0] waitReg;
  logic [waitW-1:0] waitCnt;
  logic [waitW-1:0] waitLoad;
  logic             strobing;
  logic             lastCycle;

  // ---------------------------------------------------------------------
  // wait-state register
  // ---------------------------------------------------------------------
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      waitReg <= waitRst;
    end else if (cfgWe && (cfgReg_e'(cfgAddr) == cfgWait)) begin
      waitReg <= cfgData;
    end
  end

  assign waitLoad = waitReg[int'(gntRegion)*waitW +: waitW];  // nibble of the region

  // ---------------------------------------------------------------------
  // bus cycle FSM
  // ---------------------------------------------------------------------
  assign strobing  = (state == sStrobe);
  assign lastCycle = strobing & (waitCnt == '0);

  always_comb begin
    nextState = state;
    case (state)
      sIdle: begin
        if (gntStart) begin
          nextState = sStrobe;
        end
      end
      sStrobe: begin
        if (lastCycle) begin
          nextState = sDone;
        end
      end
      sDone:   nextState = sIdle;
      default: nextState = sIdle;
    endcase
  end

  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      state <= sIdle;
    end else begin
      state <= nextState;
    end
  end

  // counts the extra strobe cycles
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      waitCnt <= '0;
    end else if (gntStart) begin
      waitCnt <= waitLoad;
    end else if (strobing && !lastCycle) begin
      waitCnt <= waitCnt - 1'b1;
    end
  end

  // ---------------------------------------------------------------------
  // registered strobes, one cycle behind the state
  // ---------------------------------------------------------------------
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      pmSelN  <= 1'b1;
      dmSelN  <= 1'b1;
      ioSelN  <= 1'b1;
      dmaSelN <= 1'b1;
      rdN     <= 1'b1;
      wrN     <= 1'b1;
      extDoe  <= 1'b0;
      seqDone <= 1'b0;
    end else begin
      pmSelN  <= ~(strobing & regionSel[rgnPm]);
      dmSelN  <= ~(strobing & regionSel[rgnDm]);
      ioSelN  <= ~(strobing & regionSel[rgnIo]);
      dmaSelN <= ~(strobing & regionSel[rgnDma]);
      rdN     <= ~(strobing & ~gntWrite);
      wrN     <= ~(strobing & gntWrite);
      // data held one cycle past the rising wrN
      extDoe  <= gntWrite & (strobing | (state == sDone));
      seqDone <= (state == sDone);
    end
  end

  // write data taken at acceptance, read data at the last strobe edge
  always_ff @(posedge DSPCLK) begin
    if (gntStart) begin
      extDout <= gntWdata;
    end
    if ((state == sDone) && !gntWrite) begin
      rdData <= extDin;
    end
  end

  assign seqIdle = (state == sIdle) & ~seqDone;  // no accept during done

endmodule

// ==== src/emcTop.sv ====
`timescale 1ns/1ps

module emcTop
  import emcPkg::*;
(
  input  logic                DSPCLK,
  input  logic                PPclr,
  // ---------------------------------------------------------------------
  // requesters
  // ---------------------------------------------------------------------
  input  logic                pmValid,
  input  logic                pmWrite,
  input  logic [reqAddrW-1:0] pmAddr,
  input  logic [dataW-1:0]    pmWdata,
  output logic                pmReady,
  output logic                pmDone,
  input  logic                dmValid,
  input  logic                dmWrite,
  input  logic [reqAddrW-1:0] dmAddr,
  input  logic [dataW-1:0]    dmWdata,
  output logic                dmReady,
  output logic                dmDone,
  input  logic                ioValid,
  input  logic                ioWrite,
  input  logic [ioAddrW-1:0]  ioAddr,
  input  logic [dataW-1:0]    ioWdata,
  output logic                ioReady,
  output logic                ioDone,
  input  logic                dmaValid,
  input  logic                dmaWrite,
  input  logic [reqAddrW-1:0] dmaAddr,
  input  logic [dataW-1:0]    dmaWdata,
  output logic                dmaReady,
  output logic                dmaDone,
  input  logic                dmaPage,
  output logic [dataW-1:0]    rdData,
  // config
  input  logic                cfgWe,
  input  logic                cfgAddr,
  input  logic [dataW-1:0]    cfgData,
  // ---------------------------------------------------------------------
  // external bus
  // ---------------------------------------------------------------------
  output logic [addrW-1:0]    extAddr,
  output logic [dataW-1:0]    extDout,
  output logic                extDoe,
  input  logic [dataW-1:0]    extDin,
  output logic                pmSelN,
  output logic                dmSelN,
  output logic                ioSelN,
  output logic                dmaSelN,
  output logic                rdN,
  output logic                wrN
);

  logic                gntStart;
  emcRegion_e          gntRegion;
  logic                gntWrite;
  logic [reqAddrW-1:0] gntAddr;
  logic [dataW-1:0]    gntWdata;
  logic [rgnN-1:0]     regionSel;
  logic                seqIdle;
  logic                seqDone;

  emcArbiter i_emcArbiter (
    .DSPCLK   (DSPCLK),
    .PPclr    (PPclr),
    .pmValid  (pmValid),
    .pmWrite  (pmWrite),
    .pmAddr   (pmAddr),
    .pmWdata  (pmWdata),
    .pmReady  (pmReady),
    .pmDone   (pmDone),
    .dmValid  (dmValid),
    .dmWrite  (dmWrite),
    .dmAddr   (dmAddr),
    .dmWdata  (dmWdata),
    .dmReady  (dmReady),
    .dmDone   (dmDone),
    .ioValid  (ioValid),
    .ioWrite  (ioWrite),
    .ioAddr   (ioAddr),
    .ioWdata  (ioWdata),
    .ioReady  (ioReady),
    .ioDone   (ioDone),
    .dmaValid (dmaValid),
    .dmaWrite (dmaWrite),
    .dmaAddr  (dmaAddr),
    .dmaWdata (dmaWdata),
    .dmaReady (dmaReady),
    .dmaDone  (dmaDone),
    .seqIdle  (seqIdle),
    .seqDone  (seqDone),
    .gntStart (gntStart),
    .gntRegion(gntRegion),
    .gntWrite (gntWrite),
    .gntAddr  (gntAddr),
    .gntWdata (gntWdata)
  );

  emcAddrMap i_emcAddrMap (
    .DSPCLK   (DSPCLK),
    .PPclr    (PPclr),
    .cfgWe    (cfgWe),
    .cfgAddr  (cfgAddr),
    .cfgData  (cfgData),
    .gntRegion(gntRegion),
    .gntAddr  (gntAddr),
    .dmaPage  (dmaPage),
    .extAddr  (extAddr),
    .regionSel(regionSel)
  );

  emcSequencer i_emcSequencer (
    .DSPCLK   (DSPCLK),
    .PPclr    (PPclr),
    .cfgWe    (cfgWe),
    .cfgAddr  (cfgAddr),
    .cfgData  (cfgData),
    .gntStart (gntStart),
    .gntRegion(gntRegion),
    .gntWrite (gntWrite),
    .gntWdata (gntWdata),
    .regionSel(regionSel),
    .extDin   (extDin),
    .pmSelN   (pmSelN),
    .dmSelN   (dmSelN),
    .ioSelN   (ioSelN),
    .dmaSelN  (dmaSelN),
    .rdN      (rdN),
    .wrN      (wrN),
    .extDout  (extDout),
    .extDoe   (extDoe),
    .rdData   (rdData),
    .seqIdle  (seqIdle),
    .seqDone  (seqDone)
  );

endmodule

// ==== sim/emcTop_asserts.sv ====
`timescale 1ns/1ps

module emcTopAsserts (
  input logic DSPCLK,
  input logic PPclr,
  input logic pmSelN,
  input logic dmSelN,
  input logic ioSelN,
  input logic dmaSelN,
  input logic rdN,
  input logic wrN,
  input logic pmDone,
  input logic dmDone,
  input logic ioDone,
  input logic dmaDone,
  input logic pmReady,
  input logic dmReady,
  input logic ioReady,
  input logic dmaReady
);

  logic [3:0] dones;
  logic [3:0] readys;

  assign dones  = {dmaDone, ioDone, dmDone, pmDone};
  assign readys = {dmaReady, ioReady, dmReady, pmReady};

  selOneHot: assert property (@(posedge DSPCLK) disable iff (PPclr)
    $onehot0({~pmSelN, ~dmSelN, ~ioSelN, ~dmaSelN}))
    else $error("more than one select low");

  strobeExcl: assert property (@(posedge DSPCLK) disable iff (PPclr) rdN || wrN)
    else $error("rdN and wrN low together");

  donePulse: assert property (@(posedge DSPCLK) disable iff (PPclr)
    (|dones) |=> !(|dones))
    else $error("done pulse longer than one cycle");

  // no grant while a cycle is on the bus
  readyIdle: assert property (@(posedge DSPCLK) disable iff (PPclr)
    (|readys) |-> (!(|dones) && rdN && wrN && pmSelN && dmSelN && ioSelN && dmaSelN))
    else $error("ready high during a bus cycle");

  // the cycle after an acceptance is already busy
  readyGap: assert property (@(posedge DSPCLK) disable iff (PPclr)
    (|readys) |=> !(|readys))
    else $error("ready high in the cycle after an acceptance");

endmodule

bind emcTop emcTopAsserts i_emcTopAsserts (
  .DSPCLK(DSPCLK), .PPclr(PPclr),
  .pmSelN(pmSelN), .dmSelN(dmSelN), .ioSelN(ioSelN), .dmaSelN(dmaSelN),
  .rdN(rdN), .wrN(wrN),
  .pmDone(pmDone), .dmDone(dmDone), .ioDone(ioDone), .dmaDone(dmaDone),
  .pmReady(pmReady), .dmReady(dmReady), .ioReady(ioReady), .dmaReady(dmaReady)
);

// ==== sim/emcTb.sv ====
`timescale 1ns/1ps

module emcTb
  import emcPkg::*;
;

  localparam int goldCols = 7;
  localparam int goldMax  = 64;
  localparam int tmo      = 100;  // cycles per wait

  logic                DSPCLK;
  logic                PPclr;
  logic                pmValid, pmWrite, pmReady, pmDone;
  logic [reqAddrW-1:0] pmAddr;
  logic [dataW-1:0]    pmWdata;
  logic                dmValid, dmWrite, dmReady, dmDone;
  logic [reqAddrW-1:0] dmAddr;
  logic [dataW-1:0]    dmWdata;
  logic                ioValid, ioWrite, ioReady, ioDone;
  logic [ioAddrW-1:0]  ioAddr;
  logic [dataW-1:0]    ioWdata;
  logic                dmaValid, dmaWrite, dmaReady, dmaDone;
  logic [reqAddrW-1:0] dmaAddr;
  logic [dataW-1:0]    dmaWdata;
  logic                dmaPage;
  logic [dataW-1:0]    rdData;
  logic                cfgWe;
  logic                cfgAddr;
  logic [dataW-1:0]    cfgData;
  logic [addrW-1:0]    extAddr;
  logic [dataW-1:0]    extDout;
  logic                extDoe;
  logic [dataW-1:0]    extDin = '0;
  logic                pmSelN, dmSelN, ioSelN, dmaSelN, rdN, wrN;

  logic [15:0] gold [0:goldCols*goldMax-1];
  logic [15:0] extMem [int];  // sparse external memory
  logic [15:0] refMem [int];  // what the testbench expects to be stored
  int          errCnt;
  int          testsRun;
  int          testsBad;
  logic [31:0] lcgState;
  logic [15:0] waitT;  // mirror of the wait register
  logic [2:0]  pmPg;
  logic [1:0]  dmPg;

  emcTop i_emcTop (.*);

  initial DSPCLK = 1'b0;
  always #2 DSPCLK = ~DSPCLK;

  // ---------------------------------------------------------------------
  // external memory model
  // ---------------------------------------------------------------------
  function automatic logic [15:0] fillWord(input logic [14:0] a);
    return {a, 1'b0} ^ 16'ha5c3;
  endfunction

  always @(negedge DSPCLK) begin
    if (!rdN) begin
      extDin <= extMem.exists(int'(extAddr)) ? extMem[int'(extAddr)] : fillWord(extAddr);
    end else begin
      extDin <= '0;
    end
  end

  always @(posedge wrN) begin
    if (extDoe) begin
      extMem[int'(extAddr)] = extDout;
    end
  end

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------
  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [14:0] mapAddr(input int rgn, input logic [13:0] a);
    case (rgn)
      0:       return {pmPg, a[11:0]};
      1:       return {dmPg, a[12:0]};
      2:       return {4'b0, a[10:0]};
      default: return {dmaPage, a[13:0]};
    endcase
  endfunction

  function automatic logic [15:0] expectRead(input logic [14:0] a);
    return refMem.exists(int'(a)) ? refMem[int'(a)] : fillWord(a);
  endfunction

  function automatic logic [3:0] readyVec();
    return {dmaReady, ioReady, dmReady, pmReady};
  endfunction

  function automatic logic [3:0] doneVec();
    return {dmaDone, ioDone, dmDone, pmDone};
  endfunction

  function automatic logic [3:0] selVec();
    return ~{dmaSelN, ioSelN, dmSelN, pmSelN};
  endfunction

  task automatic setReq(input int rgn, input logic v, input logic w,
                        input logic [13:0] a, input logic [15:0] d);
    case (rgn)
      0: begin
        pmValid = v;
        pmWrite = w;
        pmAddr  = a;
        pmWdata = d;
      end
      1: begin
        dmValid = v;
        dmWrite = w;
        dmAddr  = a;
        dmWdata = d;
      end
      2: begin
        ioValid = v;
        ioWrite = w;
        ioAddr  = a[10:0];
        ioWdata = d;
      end
      default: begin
        dmaValid = v;
        dmaWrite = w;
        dmaAddr  = a;
        dmaWdata = d;
      end
    endcase
  endtask

  task automatic cfgWrite(input logic code, input logic [15:0] d);
    @(negedge DSPCLK);
    cfgWe   = 1'b1;
    cfgAddr = code;
    cfgData = d;
    @(negedge DSPCLK);
    cfgWe = 1'b0;
    if (code == cfgWait) begin
      waitT = d;
    end else begin
      pmPg = d[2:0];
      dmPg = d[5:4];
    end
  endtask

  task automatic applyReset();
    @(negedge DSPCLK);
    for (int r = 0; r < 4; r++) setReq(r, 1'b0, 1'b0, '0, '0);
    cfgWe = 1'b0;
    PPclr = 1'b1;
    repeat (2) @(negedge DSPCLK);
    PPclr = 1'b0;
    waitT = '0;
    pmPg  = '0;
    dmPg  = '0;
  endtask

  task automatic checkIdleOutputs();
    if (selVec() != 4'h0) begin
      $display("Error selects: got %h expected %h", selVec(), 4'h0);
      errCnt++;
    end
    if (!rdN || !wrN) begin
      $display("Error rdN/wrN: got %h expected %h", {rdN, wrN}, 2'h3);
      errCnt++;
    end
    if (extDoe || doneVec() != 4'h0) begin
      $display("Error extDoe/done: got %h expected %h", {extDoe, doneVec()}, 5'h0);
      errCnt++;
    end
  endtask

  task automatic endTest(input string name, input int errBefore);
    testsRun++;
    if (errCnt > errBefore) begin
      testsBad++;
      $display("test %0d %s: FAILED", testsRun, name);
    end else begin
      $display("test %0d %s: ok", testsRun, name);
    end
  endtask

  // one external cycle from accept to done with the first strobe cycle sampled
  task automatic busOp(input int rgn, input logic w, input logic [13:0] a,
                       input logic [15:0] d, output logic [15:0] rd, output int lat,
                       output logic [14:0] seenAddr, output logic [3:0] seenSel);
    int n;
    logic gotSel;
    logic [3:0] rv;
    logic [3:0] dv;
    rd = '0;
    lat = 0;
    seenAddr = '0;
    seenSel = '0;
    gotSel = 1'b0;
    n = 0;
    @(negedge DSPCLK);
    setReq(rgn, 1'b1, w, a, d);
    #1;
    while (n < tmo) begin
      rv = readyVec();
      if (rv[rgn]) break;
      @(negedge DSPCLK);
      #1;
      n++;
    end
    if (n >= tmo) begin
      $display("timeout: region %0d was never granted", rgn);
      errCnt++;
      setReq(rgn, 1'b0, w, a, d);
      return;
    end
    @(negedge DSPCLK);  // acceptance edge has passed
    setReq(rgn, 1'b0, w, a, d);
    while (lat < tmo) begin
      if (!gotSel && selVec() != 4'h0) begin
        gotSel   = 1'b1;
        seenAddr = extAddr;
        seenSel  = selVec();
      end
      dv = doneVec();
      if (dv != 4'h0) begin
        if (dv != (4'h1 << rgn)) begin
          $display("Error done: got %h expected %h", dv, 4'h1 << rgn);
          errCnt++;
        end
        rd = rdData;
        break;
      end
      @(negedge DSPCLK);
      lat++;
    end
    if (lat >= tmo) begin
      $display("timeout: no done pulse for region %0d", rgn);
      errCnt++;
    end
  endtask

  // common checks after busOp
  task automatic checkOp(input int rgn, input logic w, input logic [15:0] rd,
                         input int lat, input logic [14:0] seenAddr,
                         input logic [3:0] seenSel, input logic [14:0] expAddr,
                         input logic [15:0] expRd, input int expLat);
    if (lat != expLat) begin
      $display("Error latency: got %h expected %h", lat, expLat);
      errCnt++;
    end
    if (seenAddr != expAddr) begin
      $display("Error extAddr: got %h expected %h", seenAddr, expAddr);
      errCnt++;
    end
    if (seenSel != (4'h1 << rgn)) begin
      $display("Error selects: got %h expected %h", seenSel, 4'h1 << rgn);
      errCnt++;
    end
    if (!w && rd != expRd) begin
      $display("Error rdData: got %h expected %h", rd, expRd);
      errCnt++;
    end
  endtask

  // ---------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------
  task automatic runGolden();
    int base;
    int e0;
    int rgn;
    int lat;
    logic [15:0] op;
    logic [15:0] rd;
    logic [14:0] sa;
    logic [3:0]  ss;
    for (int i = 0; i < goldMax; i++) begin
      base = i * goldCols;
      op   = gold[base];
      rgn  = int'(gold[base+1]);
      if (op == 16'h000f) break;
      if (op == 16'h0000) begin
        cfgWrite(gold[base+1][0], gold[base+3]);
      end else if (op == 16'h0003) begin
        @(negedge DSPCLK);
        dmaPage = gold[base+3][0];
      end else begin
        e0 = errCnt;
        busOp(rgn, op == 16'h0001, gold[base+2][13:0], gold[base+3], rd, lat, sa, ss);
        checkOp(rgn, op == 16'h0001, rd, lat, sa, ss, gold[base+5][14:0],
                gold[base+4], int'(gold[base+6]));
        if (op == 16'h0001) refMem[int'(gold[base+5][14:0])] = gold[base+3];
        endTest($sformatf("golden line %0d region %0d", i, rgn), e0);
      end
    end
  endtask

  task automatic burstOrder();
    int e0;
    int n;
    int q[$];
    logic [13:0] ba [4];
    logic [3:0] rv;
    logic [3:0] dv;
    e0 = errCnt;
    n = 0;
    ba[0] = 14'h0a0a;
    ba[1] = 14'h0b0b;
    ba[2] = 14'h0777;
    ba[3] = 14'h1234;
    @(negedge DSPCLK);
    for (int r = 0; r < 4; r++) setReq(r, 1'b1, 1'b0, ba[r], '0);
    while (q.size() < 4 && n < tmo * 4) begin
      #1;
      rv = readyVec();
      dv = doneVec();
      if ($countones(dv) > 1) begin
        $display("two done pulses overlap: %h", dv);
        errCnt++;
      end
      for (int r = 0; r < 4; r++) begin
        if (dv[r]) begin
          q.push_back(r);
          if (rdData != expectRead(mapAddr(r, ba[r]))) begin
            $display("Error rdData: got %h expected %h", rdData,
                     expectRead(mapAddr(r, ba[r])));
            errCnt++;
          end
        end
      end
      @(negedge DSPCLK);
      for (int r = 0; r < 4; r++) begin
        if (rv[r]) setReq(r, 1'b0, 1'b0, ba[r], '0);
      end
      n++;
    end
    if (q.size() < 4) begin
      $display("timeout: only %0d of 4 simultaneous requests completed", q.size());
      errCnt++;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (q[i] != i) begin
          $display("Error done order: got %h expected %h", q[i], i);
          errCnt++;
        end
      end
    end
    endTest("simultaneous requests in priority order", e0);
  endtask

  task automatic randomMix();
    int e0;
    int rgn;
    int lat;
    logic w;
    logic [13:0] a;
    logic [15:0] d;
    logic [15:0] rd;
    logic [14:0] sa;
    logic [14:0] ea;
    logic [3:0]  ss;
    e0 = errCnt;
    for (int k = 0; k < 200; k++) begin
      if (k % 50 == 0) begin  // new waits and pages now and then
        lcgState = lcgNext(lcgState);
        cfgWrite(cfgWait, lcgState[31:16]);
        lcgState = lcgNext(lcgState);
        cfgWrite(cfgOvl, lcgState[31:16]);
        @(negedge DSPCLK);
        dmaPage = lcgState[8];
      end
      lcgState = lcgNext(lcgState);
      rgn = int'(lcgState[17:16]);
      w   = lcgState[20];
      a   = {1'b0, lcgState[30], 6'h0, lcgState[29:24]};
      d   = lcgState[15:0];
      ea  = mapAddr(rgn, a);
      busOp(rgn, w, a, d, rd, lat, sa, ss);
      checkOp(rgn, w, rd, lat, sa, ss, ea, expectRead(ea), int'(waitT[rgn*4 +: 4]) + 2);
      if (w) refMem[int'(ea)] = d;
    end
    endTest("random mix of 200 operations", e0);
  endtask

  task automatic midCycleReset();
    int e0;
    int n;
    int lat;
    logic [15:0] rd;
    logic [14:0] sa;
    logic [3:0]  ss;
    e0 = errCnt;
    n = 0;
    cfgWrite(cfgWait, 16'hffff);
    @(negedge DSPCLK);
    setReq(0, 1'b1, 1'b0, 14'h0123, '0);
    #1;
    while (!pmReady && n < tmo) begin
      @(negedge DSPCLK);
      #1;
      n++;
    end
    if (n >= tmo) begin
      $display("timeout: pm request before reset was never granted");
      errCnt++;
    end
    @(negedge DSPCLK);
    setReq(0, 1'b0, 1'b0, 14'h0123, '0);
    repeat (3) @(negedge DSPCLK);
    if (rdN) begin
      $display("read strobe not active before the reset");
      errCnt++;
    end
    applyReset();
    checkIdleOutputs();
    busOp(0, 1'b0, 14'h0123, '0, rd, lat, sa, ss);
    checkOp(0, 1'b0, rd, lat, sa, ss, mapAddr(0, 14'h0123), expectRead(mapAddr(0, 14'h0123)), 2);
    endTest("reset in the middle of a cycle", e0);
  endtask

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------
  initial begin
    int e0;
    int lat;
    logic [15:0] rd;
    logic [14:0] sa;
    logic [3:0]  ss;
    PPclr    = 1'b1;
    cfgWe    = 1'b0;
    cfgAddr  = 1'b0;
    cfgData  = '0;
    dmaPage  = 1'b0;
    errCnt   = 0;
    testsRun = 0;
    testsBad = 0;
    lcgState = 32'h1808_acb9;
    waitT    = '0;
    pmPg     = '0;
    dmPg     = '0;
    for (int r = 0; r < 4; r++) setReq(r, 1'b0, 1'b0, '0, '0);
    $readmemh("sim/emc_golden.txt", gold);

    applyReset();
    e0 = errCnt;
    checkIdleOutputs();
    busOp(2, 1'b0, 14'h0010, '0, rd, lat, sa, ss);
    checkOp(2, 1'b0, rd, lat, sa, ss, mapAddr(2, 14'h0010), expectRead(mapAddr(2, 14'h0010)), 2);
    endTest("state after reset", e0);

    runGolden();
    burstOrder();
    randomMix();
    midCycleReset();

    $display("tests %0d, failed %0d, errors %0d", testsRun, testsBad, errCnt);
    if (errCnt == 0 && testsBad == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("timeout: simulation did not reach the end");
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== sim/emc_golden.txt ====
// columns (hex): op region addr data expRdData expExtAddr latency
// op 0 config (region 0 wait, 1 overlay), 1 write, 2 read, 3 set dmaPage, f end
1 0 0123 1111 0000 0123 2
2 0 0123 0000 1111 0123 2
1 1 1456 2222 0000 1456 2
2 1 1456 0000 2222 1456 2
1 2 0345 3333 0000 0345 2
2 2 0345 0000 3333 0345 2
1 3 2abc 4444 0000 2abc 2
2 3 2abc 0000 4444 2abc 2
// waits pm 1, dm 3, io 2, dma 5
0 0 0000 5231 0000 0000 0
1 0 0a0a 5555 0000 0a0a 3
2 0 0a0a 0000 5555 0a0a 3
1 1 0b0b 6666 0000 0b0b 5
2 1 0b0b 0000 6666 0b0b 5
1 2 0777 7777 0000 0777 4
2 2 0777 0000 7777 0777 4
1 3 1234 8888 0000 1234 7
2 3 1234 0000 8888 1234 7
// pm page 5, dm page 2
0 1 0000 0025 0000 0000 0
1 0 0123 9999 0000 5123 3
2 0 0123 0000 9999 5123 3
2 0 3123 0000 9999 5123 3
1 1 0456 aaaa 0000 4456 5
2 1 0456 0000 aaaa 4456 5
3 0 0000 0001 0000 0000 0
1 3 0abc bbbb 0000 4abc 7
2 3 0abc 0000 bbbb 4abc 7
0 0 0000 0000 0000 0000 0
2 0 0123 0000 9999 5123 2
0 1 0000 0000 0000 0000 0
3 0 0000 0000 0000 0000 0
2 1 1456 0000 2222 1456 2
2 3 2abc 0000 4444 2abc 2
f 0 0000 0000 0000 0000 0

// ==== sources.f ====
common/emcPkg.sv
emc/emcArbiter.sv
emc/emcAddrMap.sv
emc/emcSequencer.sv
src/emcTop.sv
sim/emcTop_asserts.sv
sim/emcTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = emcTb
FILELIST = sources.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
